/* hdl/zx_defines.svh */
`ifndef ZX_DEFINES_SVH
`define ZX_DEFINES_SVH

// ==========================================================================
// Memory geometry
// ==========================================================================
// Offset inside one 16K bank
`define ZX_OFFSET_W 14
`define ZX_BANK_W 4
`define ZX_NUM_BANKS 10

// Physical bank numbers, ROMs sit above the eight RAM banks
`define ZX_ROM0_BANK 4'd8
`define ZX_ROM1_BANK 4'd9
`define ZX_SCREEN_BANK 4'd5
`define ZX_MID_BANK 4'd2

// ==========================================================================
// I/O decode
// ==========================================================================
`define ZX_KEMPSTON_PORT 6'h1F
`define ZX_IDLE_BYTE 8'hFF

`endif

/* hdl/zx_pkg.sv */
`include "zx_defines.svh"

package zx_pkg;

	// One CPU address word, seen either as a memory or an I/O address
	typedef union packed {
		// Memory view: 16K region and offset inside it
		struct packed {
			logic [1:0] region;
			logic [`ZX_OFFSET_W-1:0] offset;
		} mem;
		// I/O view: B register on the high byte, port on the low byte
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} io;
	} zx_addr_u;

	// Physical bank, 0-7 RAM and 8-9 ROM
	typedef logic [`ZX_BANK_W-1:0] zx_bank_t;

	// Address into the flat physical space
	typedef struct packed {
		zx_bank_t bank;
		logic [`ZX_OFFSET_W-1:0] offset;
	} zx_phys_addr_t;

endpackage

/* hdl/zx_bus_if.sv */
`timescale 1ns/1ns

// One decoded CPU access, driven by the bus controller
interface zx_bus_if;
	import zx_pkg::*;

	zx_addr_u adr;
	logic [7:0] dat_w;
	// One-cycle strobes
	logic mem_wr;
	logic io_wr;
	logic io_rd;

	modport ctrl (output adr, output dat_w, output mem_wr, output io_wr, output io_rd);

	modport pager (input adr, input dat_w, input io_wr);

	modport ula (input adr, input dat_w, input io_wr, input io_rd);

endinterface

/* hdl/zx_bus_ctrl.sv */
`timescale 1ns/1ns
`include "zx_defines.svh"

module zx_bus_ctrl (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic [15:0] wb_adr,
	input  logic [7:0] wb_dat_w,
	output logic [7:0] wb_dat_r,
	input  logic       wb_we,
	input  logic       wb_cyc,
	input  logic       wb_stb,
	output logic       wb_ack,
	input  logic       wb_io,
	zx_bus_if.ctrl     bus,
	input  logic [7:0] ram_rdata,
	input  logic       mem_grant,
	input  logic       ula_sel,
	input  logic [7:0] ula_rdata
);
	import zx_pkg::*;

	// Access sequence, fixed two-cycle latency to ack
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_STROBE = 2'd1;
	localparam logic [1:0] ST_WAIT = 2'd2;
	localparam logic [1:0] ST_ACK = 2'd3;

	logic [1:0] state;
	logic [7:0] rd_sel;

	// Address and data are held stable by the master for the whole access
	assign bus.adr = zx_addr_u'(wb_adr);
	assign bus.dat_w = wb_dat_w;

	// Memory first, then ULA or joystick, else the floating bus value
	assign rd_sel = !wb_io ? ram_rdata : (ula_sel ? ula_rdata : `ZX_IDLE_BYTE);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= ST_IDLE;
			bus.mem_wr <= 1'b0;
			bus.io_wr <= 1'b0;
			bus.io_rd <= 1'b0;
		end else begin
			bus.mem_wr <= 1'b0;
			bus.io_wr <= 1'b0;
			bus.io_rd <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (wb_cyc && wb_stb) begin
						state <= ST_STROBE;
						// ROM region writes are dropped here
						bus.mem_wr <= !wb_io && wb_we && mem_grant;
						bus.io_wr <= wb_io && wb_we;
						bus.io_rd <= wb_io && !wb_we;
					end
				end
				ST_STROBE: state <= ST_WAIT;
				ST_WAIT: state <= ST_ACK;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// RAM output and ULA select are both valid during the wait cycle
	always_ff @(posedge clk_sys) begin
		if (state == ST_WAIT)
			wb_dat_r <= rd_sel;
	end

	assign wb_ack = (state == ST_ACK);

endmodule

/* hdl/zx_pager.sv */
`timescale 1ns/1ns
`include "zx_defines.svh"

module zx_pager (
	input  logic                  clk_sys,
	input  logic                  reset,
	zx_bus_if.pager               bus,
	output zx_pkg::zx_phys_addr_t phys_addr,
	output logic                  mem_grant
);
	import zx_pkg::*;

	// 7FFD byte
	//   2:0 RAM bank at C000
	//   3   screen select, kept but unused without video
	//   4   ROM select
	//   5   lock until reset
	logic [7:0] page_reg;
	logic page_sel;
	zx_bank_t bank;

	// ==========================================================================
	// Paging register
	// ==========================================================================

	// Partial decode as on the real machine, A15 and A1 low
	assign page_sel = !bus.adr.io.hi[7] && !bus.adr.io.lo[1];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_reg <= 8'h00;
		end else if (bus.io_wr && page_sel && !page_reg[5]) begin
			page_reg <= bus.dat_w;
		end
	end

	// ==========================================================================
	// Address translation
	// ==========================================================================

	always_comb begin
		case (bus.adr.mem.region)
			2'd0: bank = page_reg[4] ? `ZX_ROM1_BANK : `ZX_ROM0_BANK;
			2'd1: bank = `ZX_SCREEN_BANK;
			2'd2: bank = `ZX_MID_BANK;
			default: bank = {1'b0, page_reg[2:0]};
		endcase
	end

	assign phys_addr.bank = bank;
	assign phys_addr.offset = bus.adr.mem.offset;

	// ROM lives in region 0, nothing else is protected
	assign mem_grant = (bus.adr.mem.region != 2'd0);

endmodule

/* hdl/zx_ula_port.sv */
`timescale 1ns/1ns
`include "zx_defines.svh"

module zx_ula_port (
	input  logic        clk_sys,
	input  logic        reset,
	zx_bus_if.ula       bus,
	input  logic [39:0] kbd_matrix,
	input  logic [5:0]  joy,
	input  logic        ear_in,
	output logic        ula_sel,
	output logic [7:0]  ula_rdata,
	output logic [2:0]  border_color,
	output logic        ear_out,
	output logic        mic_out
);
	import zx_pkg::*;

	logic fe_hit;
	logic kempston_hit;
	logic [4:0] pressed;

	// Any even port is the ULA
	assign fe_hit = !bus.adr.io.lo[0];
	assign kempston_hit = (bus.adr.io.lo[5:0] == `ZX_KEMPSTON_PORT);

	// Output latch
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= 3'd0;
			ear_out <= 1'b0;
			mic_out <= 1'b0;
		end else if (bus.io_wr && fe_hit) begin
			border_color <= bus.dat_w[2:0];
			ear_out <= bus.dat_w[4];
			mic_out <= bus.dat_w[3];
		end
	end

	// Select flag follows the read strobe by one cycle
	always_ff @(posedge clk_sys) begin
		if (reset)
			ula_sel <= 1'b0;
		else
			ula_sel <= bus.io_rd && (fe_hit || kempston_hit);
	end

	// Half-rows with a low address line are scanned together
	always_comb begin
		pressed = 5'd0;
		for (int i = 0; i < 8; i++) begin
			if (!bus.adr.io.hi[i])
				pressed = pressed | kbd_matrix[i*5 +: 5];
		end
	end

	assign ula_rdata = fe_hit ? {1'b1, ~ear_in, 1'b1, ~pressed} : {2'b00, joy};

endmodule

/* hdl/zx_ram.sv */
`timescale 1ns/1ns
`include "zx_defines.svh"

module zx_ram (
	input  logic                  clk_sys,
	input  zx_pkg::zx_phys_addr_t phys_addr,
	input  logic [7:0]            wdata,
	input  logic                  we,
	input  logic                  load_wr,
	input  zx_pkg::zx_phys_addr_t load_addr,
	input  logic [7:0]            load_data,
	output logic [7:0]            rdata
);
	import zx_pkg::*;

	localparam int DEPTH = `ZX_NUM_BANKS << `ZX_OFFSET_W;

	// Banks are contiguous, so the physical address indexes directly
	logic [7:0] mem [DEPTH];

	// Loader has priority over the CPU side
	always_ff @(posedge clk_sys) begin
		if (load_wr)
			mem[load_addr] <= load_data;
		else if (we)
			mem[phys_addr] <= wdata;
	end

	// Registered read on the bus address
	always_ff @(posedge clk_sys) begin
		rdata <= mem[phys_addr];
	end

endmodule

/* hdl/zx_top.sv */
`timescale 1ns/1ns
`include "zx_defines.svh"

module zx_top (
	input  logic        clk_sys,
	input  logic        reset,
	// Wishbone classic slave
	input  logic [15:0] wb_adr,
	input  logic [7:0]  wb_dat_w,
	output logic [7:0]  wb_dat_r,
	input  logic        wb_we,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	output logic        wb_ack,
	input  logic        wb_io,
	// Loader
	input  logic        load_wr,
	input  logic [`ZX_BANK_W+`ZX_OFFSET_W-1:0] load_addr,
	input  logic [7:0]  load_data,
	// Keyboard, joystick and tape
	input  logic [39:0] kbd_matrix,
	input  logic [5:0]  joy,
	input  logic        ear_in,
	output logic [2:0]  border_color,
	output logic        ear_out,
	output logic        mic_out
);
	import zx_pkg::*;

	zx_phys_addr_t phys_addr;
	logic mem_grant;
	logic ula_sel;
	logic [7:0] ula_rdata;
	logic [7:0] ram_rdata;

	zx_bus_if bus_inst ();

	zx_bus_ctrl bus_ctrl_inst (
		.clk_sys, .reset,
		.wb_adr, .wb_dat_w, .wb_dat_r, .wb_we, .wb_cyc, .wb_stb, .wb_ack, .wb_io,
		.bus(bus_inst.ctrl),
		.ram_rdata, .mem_grant, .ula_sel, .ula_rdata
	);

	zx_pager pager_inst (
		.clk_sys, .reset,
		.bus(bus_inst.pager),
		.phys_addr, .mem_grant
	);

	zx_ula_port ula_port_inst (
		.clk_sys, .reset,
		.bus(bus_inst.ula),
		.kbd_matrix, .joy, .ear_in,
		.ula_sel, .ula_rdata,
		.border_color, .ear_out, .mic_out
	);

	zx_ram ram_inst (
		.clk_sys,
		.phys_addr,
		.wdata(bus_inst.dat_w),
		.we(bus_inst.mem_wr),
		.load_wr,
		.load_addr(zx_phys_addr_t'(load_addr)),
		.load_data,
		.rdata(ram_rdata)
	);

endmodule

/* dv/zx_props.sv */
`timescale 1ns/1ns

module zx_props (
	input logic clk_sys,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack
);

	// Count of failed assertions
	int failures = 0;

	// Ack only answers an open strobe
	ack_in_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		wb_ack |-> wb_cyc && wb_stb)
		else begin
			failures++;
			$error("wb_ack high outside cyc and stb");
		end

	ack_single: assert property (@(posedge clk_sys) disable iff (reset)
		wb_ack |=> !wb_ack)
		else begin
			failures++;
			$error("wb_ack held longer than one cycle");
		end

	// Fixed latency, ack registered two edges after the strobe is taken
	ack_latency: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(wb_cyc && wb_stb) |-> !wb_ack ##1 !wb_ack ##1 !wb_ack ##1 wb_ack)
		else begin
			failures++;
			$error("wb_ack not at the fixed latency");
		end

	ack_after_reset: assert property (@(posedge clk_sys)
		reset |=> !wb_ack)
		else begin
			failures++;
			$error("wb_ack high after reset");
		end

endmodule

bind zx_top zx_props props_inst (.clk_sys, .reset, .wb_cyc, .wb_stb, .wb_ack);

/* dv/zx_tb.sv */
`timescale 1ns/1ns
`include "zx_defines.svh"

module zx_tb;

	localparam int ACK_TIMEOUT = 20;
	localparam int RESET_CYCLES = 10;

	logic clk_sys = 1'b0;
	logic reset;
	logic [15:0] wb_adr;
	logic [7:0] wb_dat_w;
	logic [7:0] wb_dat_r;
	logic wb_we;
	logic wb_cyc;
	logic wb_stb;
	logic wb_ack;
	logic wb_io;
	logic load_wr;
	logic [`ZX_BANK_W+`ZX_OFFSET_W-1:0] load_addr;
	logic [7:0] load_data;
	logic [39:0] kbd_matrix;
	logic [5:0] joy;
	logic ear_in;
	logic [2:0] border_color;
	logic ear_out;
	logic mic_out;

	int mismatches = 0;
	int timeouts = 0;
	int trace_errors = 0;
	int reset_cycles = 0;

	zx_top zx_top_inst (.*);

	always #50 clk_sys = ~clk_sys;

	// ========================================================================
	// Helpers
	// ========================================================================

	// Bank number in the top nibble, folded with every offset bit
	function automatic logic [7:0] rom_pattern(input logic [17:0] addr);
		return {addr[17:14], 4'h0} ^ addr[7:0] ^ {2'b00, addr[13:8]};
	endfunction

	// Loader fill of the first bytes of ROM0 and ROM1
	task automatic preload_roms(input int count);
		logic [3:0] bank;
		logic [17:0] addr;
		for (int b = 0; b < 2; b++) begin
			bank = b ? `ZX_ROM1_BANK : `ZX_ROM0_BANK;
			for (int i = 0; i < count; i++) begin
				addr = {bank, i[13:0]};
				@(posedge clk_sys);
				load_wr <= 1'b1;
				load_addr <= addr;
				load_data <= rom_pattern(addr);
				reset_cycles++;
			end
		end
		@(posedge clk_sys);
		load_wr <= 1'b0;
		reset_cycles++;
	endtask

	task automatic release_reset();
		while (reset_cycles < RESET_CYCLES) begin
			@(posedge clk_sys);
			reset_cycles++;
		end
		reset <= 1'b0;
	endtask

	// One Wishbone classic cycle, ack sampled on the falling edge
	task automatic bus_access(input logic io, input logic we, input logic [15:0] adr,
			input logic [7:0] wdata, output logic [7:0] rdata);
		int waited;
		logic acked;
		waited = 0;
		acked = 1'b0;
		@(posedge clk_sys);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_io <= io;
		wb_adr <= adr;
		wb_dat_w <= wdata;
		while (!acked && waited < ACK_TIMEOUT) begin
			@(negedge clk_sys);
			if (wb_ack)
				acked = 1'b1;
			else
				waited++;
		end
		rdata = wb_dat_r;
		@(posedge clk_sys);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
		if (!acked) begin
			$display("Timeout at %0t ns: no wb_ack for access to %h", $time, adr);
			timeouts++;
		end
	endtask

	task automatic compare_value(input string name, input logic [39:0] actual,
			input logic [39:0] expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t ns: %s = %0h, expected %0h", $time, name, actual,
				expected);
			mismatches++;
		end
	endtask

	// ========================================================================
	// Trace player
	// ========================================================================

	initial begin
		int fd;
		int code;
		int ch;
		int need;
		int got;
		int assert_failures;
		logic [7:0] op;
		logic [39:0] args [3];
		logic [7:0] rdata;
		logic in_reset;

		reset = 1'b1;
		wb_adr = 16'h0000;
		wb_dat_w = 8'h00;
		wb_we = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_io = 1'b0;
		load_wr = 1'b0;
		load_addr = '0;
		load_data = 8'h00;
		kbd_matrix = 40'd0;
		joy = 6'd0;
		ear_in = 1'b0;
		in_reset = 1'b1;

		fd = $fopen("dv/zx_trace.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the trace file dv/zx_trace.txt");
			trace_errors++;
		end else begin
			code = $fscanf(fd, " %c", op);
			while (code == 1 && timeouts == 0) begin
				if (op == "#") begin
					// Skip the rest of a comment line
					ch = $fgetc(fd);
					while (ch != "\n" && ch != -1)
						ch = $fgetc(fd);
				end else begin
					need = (op == "P") ? 1 : ((op == "K" || op == "B") ? 3 : 2);
					got = 0;
					for (int k = 0; k < need; k++)
						got += $fscanf(fd, "%h", args[k]);
					if (got != need) begin
						$display("Trace line for operation %c has missing fields", op);
						trace_errors++;
						break;
					end
					if (in_reset && op != "P") begin
						release_reset();
						in_reset = 1'b0;
					end
					case (op)
						"P": preload_roms(args[0]);
						"W", "O": bus_access(op == "O", 1'b1, args[0][15:0], args[1][7:0], rdata);
						"R", "I": begin
							bus_access(op == "I", 1'b0, args[0][15:0], 8'h00, rdata);
							compare_value("wb_dat_r", rdata, args[1]);
						end
						"K": begin
							@(posedge clk_sys);
							kbd_matrix <= args[0];
							joy <= args[1][5:0];
							ear_in <= args[2][0];
						end
						"B": begin
							@(negedge clk_sys);
							compare_value("border_color", border_color, args[0]);
							compare_value("ear_out", ear_out, args[1]);
							compare_value("mic_out", mic_out, args[2]);
						end
						default: begin
							$display("Unknown trace operation %c", op);
							trace_errors++;
						end
					endcase
				end
				code = $fscanf(fd, " %c", op);
			end
			$fclose(fd);
		end

		// Let assertions still in flight complete
		repeat (2) @(negedge clk_sys);
		assert_failures = zx_top_inst.props_inst.failures;

		$display("Errors: %0d mismatches, %0d timeouts, %0d trace, %0d assertions",
			mismatches, timeouts, trace_errors, assert_failures);
		if (mismatches + timeouts + trace_errors + assert_failures == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* dv/zx_trace.txt */
# W/R adr data: memory write/read, O/I port data: I/O write/read, P n: fill n bytes per ROM
# K kbd joy ear: set inputs, B border ear mic: check pins, ROM byte = {bank,0} ^ offset
P 4
B 0 0 0
W 4000 a5
W 8000 3c
R 4000 a5
R 8000 3c
W c000 11
O 7ffd 03
W c000 77
R c000 77
O 7ffd 00
R c000 11
O 7ffd 13
R c000 77
R 0001 91
W 0001 ff
R 0001 91
O 7ffd 05
R c000 a5
R 0003 83
O 7ffd 23
O 7ffd 15
R c000 77
R 0000 80
O 00fe 0d
B 5 0 1
K 8000000001 15 1
I fefe be
I 7ffe af
I 00fe ae
I 001f 15
I 00ff ff

/* project.f */
+incdir+hdl
hdl/zx_pkg.sv
hdl/zx_bus_if.sv
hdl/zx_bus_ctrl.sv
hdl/zx_pager.sv
hdl/zx_ula_port.sv
hdl/zx_ram.sv
hdl/zx_top.sv
dv/zx_props.sv
dv/zx_tb.sv

/* Bender.yml */
package:
  name: zx_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/zx_pkg.sv
      - hdl/zx_bus_if.sv
      - hdl/zx_bus_ctrl.sv
      - hdl/zx_pager.sv
      - hdl/zx_ula_port.sv
      - hdl/zx_ram.sv
      - hdl/zx_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - dv/zx_props.sv
      - dv/zx_tb.sv
